/* pipeCtrl_config.svh */
`ifndef PIPE_CTRL_CONFIG_SVH
`define PIPE_CTRL_CONFIG_SVH

// instruction word and register file
`define INSTR_W     32
`define REG_ADDR_W  5

// fetch stays closed this many cycles after a redirect
`define JUMP_HOLD   2
`define BRANCH_HOLD 1

// hold counter, wide enough for the longest window
`define HOLD_W      2

`endif

/* pipeCtrlPkg.sv */
`include "pipeCtrl_config.svh"

package pipeCtrlPkg;

    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    ////////////////////////////////////////
    // opcodes and R-type funct codes
    ////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_BGTZ  = 6'h07;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    ////////////////////////////////////////
    // instruction word, two views
    ////////////////////////////////////////
    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmt_t;

    typedef struct packed {
        logic [5:0]                              opcode;
        regAddr_t                                rs;
        regAddr_t                                rt;
        logic [`INSTR_W-6-2*`REG_ADDR_W-1:0]     imm;   // rest of the word
    } iFmt_t;

    typedef union packed {
        rFmt_t r;
        iFmt_t i;
    } instrWord_u;

    typedef enum logic [3:0] {
        NOP,
        ALU_R,
        ALU_I,
        LOAD,
        STORE,
        BEQ,
        BNE,
        BGTZ,
        JUMP,
        JREG
    } opClass_e;

    // one instruction as seen by the hazard logic
    typedef struct packed {
        logic     valid;
        opClass_e opClass;
        regAddr_t rs;
        regAddr_t rt;
        logic     readsRs;
        logic     readsRt;
        regAddr_t dest;
        logic     writesReg;
        logic     isLoad;
    } slot_t;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdSel_e;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JREG} pcSrc_e;

endpackage

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  pipeCtrlPkg::instrWord_u instr,
    input  logic                    instrValid,
    output pipeCtrlPkg::slot_t      decSlot
);
    import pipeCtrlPkg::*;

    opClass_e opClass;

    // class by opcode, funct only for R-type
    always_comb
    begin
        opClass = NOP;
        case (instr.i.opcode)
            OP_RTYPE:
            begin
                case (instr.r.funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: opClass = ALU_R;
                    FN_JR:   opClass = JREG;
                    default: opClass = NOP;
                endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI: opClass = ALU_I;
            OP_LW:   opClass = LOAD;
            OP_SW:   opClass = STORE;
            OP_BEQ:  opClass = BEQ;
            OP_BNE:  opClass = BNE;
            OP_BGTZ: opClass = BGTZ;
            OP_J:    opClass = JUMP;
            default: opClass = NOP;    // unknown codes do nothing
        endcase
    end

    always_comb
    begin
        decSlot         = '0;
        decSlot.valid   = instrValid;
        decSlot.opClass = opClass;
        decSlot.rs      = instr.i.rs;
        decSlot.rt      = instr.i.rt;
        decSlot.isLoad  = (opClass == LOAD);

        case (opClass)
            ALU_R, STORE, BEQ, BNE:
            begin
                decSlot.readsRs = 1'b1;
                decSlot.readsRt = 1'b1;
            end
            ALU_I, LOAD, BGTZ, JREG: decSlot.readsRs = 1'b1;
            default: ;
        endcase

        // destination field depends on format
        case (opClass)
            ALU_R:       decSlot.dest = instr.r.rd;
            ALU_I, LOAD: decSlot.dest = instr.i.rt;
            default:     decSlot.dest = '0;
        endcase
        decSlot.writesReg = (opClass inside {ALU_R, ALU_I, LOAD}) && (decSlot.dest != '0);
    end

endmodule

/* slotPipe.sv */
`timescale 1ns/1ps

module slotPipe (
    input  logic               clk,
    input  logic               rst_n,
    input  pipeCtrlPkg::slot_t decSlot,
    input  logic               fetchReady,
    input  logic               stall,
    output pipeCtrlPkg::slot_t exSlot,
    output pipeCtrlPkg::slot_t memSlot,
    output pipeCtrlPkg::slot_t wbSlot
);
    import pipeCtrlPkg::*;

    localparam slot_t bubble = '0;

    logic accept;

    assign accept = decSlot.valid && fetchReady;   // fetch handshake

    ////////////////////////////////////////
    // EX / MEM / WB registers
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            exSlot  <= bubble;
            memSlot <= bubble;
            wbSlot  <= bubble;
        end
        else
        begin
            if (stall)
            begin
                // EX waits for the load, gap goes into MEM
                memSlot <= bubble;
            end
            else
            begin
                exSlot  <= accept ? decSlot : bubble;
                memSlot <= exSlot;
            end
            wbSlot <= memSlot;   // WB always drains
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // hazard unit and redirect control must agree on fetch
    assert property (@(posedge clk) disable iff (!rst_n) !(fetchReady && stall))
        else $error("fetch open during a load-use stall");

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  pipeCtrlPkg::slot_t   exSlot,
    input  pipeCtrlPkg::slot_t   memSlot,
    input  pipeCtrlPkg::slot_t   wbSlot,
    output pipeCtrlPkg::fwdSel_e fwdA,
    output pipeCtrlPkg::fwdSel_e fwdB,
    output logic                 stall
);
    import pipeCtrlPkg::*;

    logic memIsAluWriter;
    logic memIsLoadWriter;
    logic wbIsWriter;
    logic loadHitRs;
    logic loadHitRt;

    assign memIsAluWriter  = memSlot.valid && memSlot.writesReg && !memSlot.isLoad;
    assign memIsLoadWriter = memSlot.valid && memSlot.writesReg && memSlot.isLoad;
    assign wbIsWriter      = wbSlot.valid && wbSlot.writesReg;

    // nearest producer wins
    function automatic fwdSel_e pickSrc(input regAddr_t src, input logic reads);
        fwdSel_e sel;
        sel = FWD_NONE;
        if (exSlot.valid && reads)
        begin
            if (memIsAluWriter && memSlot.dest == src)
                sel = FWD_MEM;
            else if (wbIsWriter && wbSlot.dest == src)
                sel = FWD_WB;
        end
        return sel;
    endfunction

    always_comb
    begin
        fwdA = pickSrc(exSlot.rs, exSlot.readsRs);
        fwdB = pickSrc(exSlot.rt, exSlot.readsRt);
    end

    ////////////////////////////////////////
    // load-use detection
    ////////////////////////////////////////
    assign loadHitRs = exSlot.readsRs && (exSlot.rs == memSlot.dest);
    assign loadHitRt = exSlot.readsRt && (exSlot.rt == memSlot.dest);

    // load data only exists after MEM
    assign stall = exSlot.valid && memIsLoadWriter && (loadHitRs || loadHitRt);

endmodule

/* redirectCtrl.sv */
`timescale 1ns/1ps
`include "pipeCtrl_config.svh"

module redirectCtrl (
    input  logic                clk,
    input  logic                rst_n,
    input  pipeCtrlPkg::slot_t  exSlot,
    input  logic                stall,
    input  logic                instrValid,
    input  logic                aluZero,
    input  logic                aluPositive,
    output logic                fetchReady,
    output logic                pcWrite,
    output pipeCtrlPkg::pcSrc_e pcSrc
);
    import pipeCtrlPkg::*;

    localparam logic [`HOLD_W-1:0] jumpHold   = `JUMP_HOLD;
    localparam logic [`HOLD_W-1:0] branchHold = `BRANCH_HOLD;

    logic               takenBranch;
    logic               isJump;
    logic               redirect;
    logic [`HOLD_W-1:0] holdCnt;

    ////////////////////////////////////////
    // resolution in EX
    ////////////////////////////////////////
    always_comb
    begin
        case (exSlot.opClass)
            BEQ:     takenBranch = aluZero;
            BNE:     takenBranch = !aluZero;
            BGTZ:    takenBranch = aluPositive;
            default: takenBranch = 1'b0;
        endcase
    end

    assign isJump     = exSlot.opClass inside {JUMP, JREG};
    assign redirect   = exSlot.valid && !stall && (takenBranch || isJump);
    assign fetchReady = !stall && !redirect && (holdCnt == '0);

    always_comb
    begin
        pcSrc   = PC_SEQ;
        pcWrite = instrValid && fetchReady;   // advance on accept
        if (redirect)
        begin
            pcWrite = 1'b1;
            case (exSlot.opClass)
                JUMP:    pcSrc = PC_JUMP;
                JREG:    pcSrc = PC_JREG;
                default: pcSrc = PC_BRANCH;
            endcase
        end
    end

    // fetch window after a redirect
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            holdCnt <= '0;
        else if (redirect)
            holdCnt <= isJump ? jumpHold : branchHold;
        else if (holdCnt != '0)
            holdCnt <= holdCnt - 1'b1;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(holdCnt > jumpHold))
        else $error("hold counter out of range");

    // nothing is fetched in the cycle after a redirect
    assert property (@(posedge clk) disable iff (!rst_n) redirect |=> !fetchReady)
        else $error("fetch reopened right after redirect");

endmodule

/* pipeCtrlTop.sv */
`timescale 1ns/1ps
`include "pipeCtrl_config.svh"

module pipeCtrlTop (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pipeCtrlPkg::instrWord_u instr,
    input  logic                    instrValid,
    output logic                    instrReady,
    input  logic                    aluZero,
    input  logic                    aluPositive,
    output pipeCtrlPkg::fwdSel_e    fwdA,
    output pipeCtrlPkg::fwdSel_e    fwdB,
    output logic                    stall,
    output logic                    pcWrite,
    output pipeCtrlPkg::pcSrc_e     pcSrc,
    output logic                    regWrite,
    output logic [`REG_ADDR_W-1:0]  regDest,
    output logic                    memToReg
);
    import pipeCtrlPkg::*;

    slot_t decSlot;
    slot_t exSlot;
    slot_t memSlot;
    slot_t wbSlot;
    logic  fetchReady;

    instrDecoder u_dec (
        .instr      (instr),
        .instrValid (instrValid),
        .decSlot    (decSlot)
    );

    slotPipe u_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .decSlot    (decSlot),
        .fetchReady (fetchReady),
        .stall      (stall),
        .exSlot     (exSlot),
        .memSlot    (memSlot),
        .wbSlot     (wbSlot)
    );

    hazardUnit u_haz (
        .exSlot  (exSlot),
        .memSlot (memSlot),
        .wbSlot  (wbSlot),
        .fwdA    (fwdA),
        .fwdB    (fwdB),
        .stall   (stall)
    );

    redirectCtrl u_redir (
        .clk         (clk),
        .rst_n       (rst_n),
        .exSlot      (exSlot),
        .stall       (stall),
        .instrValid  (instrValid),
        .aluZero     (aluZero),
        .aluPositive (aluPositive),
        .fetchReady  (fetchReady),
        .pcWrite     (pcWrite),
        .pcSrc       (pcSrc)
    );

    assign instrReady = fetchReady;

    // register file write port from the WB slot
    assign regWrite = wbSlot.writesReg;
    assign regDest  = wbSlot.dest;
    assign memToReg = wbSlot.isLoad;

endmodule

/* tbPipeCtrl.sv */
`timescale 1ns/1ps
`include "pipeCtrl_config.svh"

module tbPipeCtrl;
    import pipeCtrlPkg::*;

    // directed part ~120 cycles, random part 400, plus holds and stalls
    localparam int MAX_CYCLES  = 1000;
    localparam int RAND_CYCLES = 400;
    localparam logic [`HOLD_W-1:0] jumpLen   = `HOLD_W'(`JUMP_HOLD);
    localparam logic [`HOLD_W-1:0] branchLen = `HOLD_W'(`BRANCH_HOLD);

    logic                   clk = 1'b0;
    logic                   rst_n;
    instrWord_u             instr;
    logic                   instrValid;
    logic                   instrReady;
    logic                   aluZero;
    logic                   aluPositive;
    fwdSel_e                fwdA;
    fwdSel_e                fwdB;
    logic                   stall;
    logic                   pcWrite;
    pcSrc_e                 pcSrc;
    logic                   regWrite;
    logic [`REG_ADDR_W-1:0] regDest;
    logic                   memToReg;

    // shadow pipeline
    slot_t              mDec;
    slot_t              mEx;
    slot_t              mMem;
    slot_t              mWb;
    logic [`HOLD_W-1:0] mHold;
    logic               taken;
    logic               expStall;
    logic               expRedirect;
    logic               expReady;
    logic               expPcWrite;
    pcSrc_e             expPcSrc;
    fwdSel_e            expFwdA;
    fwdSel_e            expFwdB;

    int   errCount    = 0;
    int   cycleCnt    = 0;
    int   acceptCount = 0;
    logic lastAccept  = 1'b0;
    int   i;

    pipeCtrlTop dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .aluZero     (aluZero),
        .aluPositive (aluPositive),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .stall       (stall),
        .pcWrite     (pcWrite),
        .pcSrc       (pcSrc),
        .regWrite    (regWrite),
        .regDest     (regDest),
        .memToReg    (memToReg)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // reference decode, straight from the ISA tables
    ////////////////////////////////////////
    function automatic slot_t decodeWord(input logic [31:0] w, input logic v);
        slot_t      s;
        logic [5:0] op;
        logic [5:0] fn;
        s       = '0;
        op      = w[31:26];
        fn      = w[5:0];
        s.valid = v;
        s.rs    = w[25:21];
        s.rt    = w[20:16];
        s.opClass = NOP;
        if (op == OP_RTYPE)
        begin
            if (fn == FN_JR)
                s.opClass = JREG;
            else if (fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT})
                s.opClass = ALU_R;
        end
        else if (op inside {OP_ADDI, OP_ANDI, OP_ORI})
            s.opClass = ALU_I;
        else if (op == OP_LW)
            s.opClass = LOAD;
        else if (op == OP_SW)
            s.opClass = STORE;
        else if (op == OP_BEQ)
            s.opClass = BEQ;
        else if (op == OP_BNE)
            s.opClass = BNE;
        else if (op == OP_BGTZ)
            s.opClass = BGTZ;
        else if (op == OP_J)
            s.opClass = JUMP;
        s.readsRt = s.opClass inside {ALU_R, STORE, BEQ, BNE};
        s.readsRs = s.readsRt || (s.opClass inside {ALU_I, LOAD, BGTZ, JREG});
        if (s.opClass == ALU_R)
            s.dest = w[15:11];           // rd
        else if (s.opClass inside {ALU_I, LOAD})
            s.dest = w[20:16];           // rt
        s.writesReg = (s.opClass inside {ALU_R, ALU_I, LOAD}) && (s.dest != '0);
        s.isLoad    = (s.opClass == LOAD);
        return s;
    endfunction

    function automatic fwdSel_e operandSource(input regAddr_t r, input logic reads,
                                              input slot_t ex, input slot_t mem,
                                              input slot_t wb);
        if (!ex.valid || !reads)
            return FWD_NONE;
        if (mem.valid && mem.writesReg && !mem.isLoad && mem.dest == r)
            return FWD_MEM;
        if (wb.valid && wb.writesReg && wb.dest == r)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb
    begin
        mDec     = decodeWord(instr, instrValid);
        expStall = mEx.valid && mMem.valid && mMem.writesReg && mMem.isLoad
                   && ((mEx.readsRs && mEx.rs == mMem.dest)
                   || (mEx.readsRt && mEx.rt == mMem.dest));
        case (mEx.opClass)
            BEQ:        taken = aluZero;
            BNE:        taken = !aluZero;
            BGTZ:       taken = aluPositive;
            JUMP, JREG: taken = 1'b1;
            default:    taken = 1'b0;
        endcase
        expRedirect = mEx.valid && !expStall && taken;
        expReady    = !expStall && !expRedirect && (mHold == '0);
        expPcWrite  = expRedirect || (instrValid && expReady);
        expPcSrc    = PC_SEQ;
        if (expRedirect)
            expPcSrc = (mEx.opClass == JUMP) ? PC_JUMP :
                       (mEx.opClass == JREG) ? PC_JREG : PC_BRANCH;
        expFwdA = operandSource(mEx.rs, mEx.readsRs, mEx, mMem, mWb);
        expFwdB = operandSource(mEx.rt, mEx.readsRt, mEx, mMem, mWb);
    end

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mEx   <= '0;
            mMem  <= '0;
            mWb   <= '0;
            mHold <= '0;
        end
        else
        begin
            if (expStall)
                mMem <= '0;                  // bubble behind the waiting consumer
            else
            begin
                mEx  <= (instrValid && expReady) ? mDec : '0;
                mMem <= mEx;
            end
            mWb <= mMem;
            if (expRedirect)
                mHold <= (mEx.opClass inside {JUMP, JREG}) ? jumpLen : branchLen;
            else if (mHold != '0)
                mHold <= mHold - `HOLD_W'(1);
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    task automatic reportValue(input string name, input int got, input int exp);
        errCount++;
        $display("ERR %0t %s: got %0d, expected %0d", $time, name, got, exp);
    endtask

    task automatic reportEvent(input string what);
        errCount++;
        $display("error at %0t: %s", $time, what);
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) stall == expStall)
        else reportValue("stall", $sampled(stall), $sampled(expStall));
    assert property (@(posedge clk) disable iff (!rst_n) instrReady == expReady)
        else reportValue("instrReady", $sampled(instrReady), $sampled(expReady));
    assert property (@(posedge clk) disable iff (!rst_n) fwdA == expFwdA)
        else reportValue("fwdA", $sampled(fwdA), $sampled(expFwdA));
    assert property (@(posedge clk) disable iff (!rst_n) fwdB == expFwdB)
        else reportValue("fwdB", $sampled(fwdB), $sampled(expFwdB));
    assert property (@(posedge clk) disable iff (!rst_n) pcWrite == expPcWrite)
        else reportValue("pcWrite", $sampled(pcWrite), $sampled(expPcWrite));
    assert property (@(posedge clk) disable iff (!rst_n) pcSrc == expPcSrc)
        else reportValue("pcSrc", $sampled(pcSrc), $sampled(expPcSrc));
    assert property (@(posedge clk) disable iff (!rst_n) regWrite == mWb.writesReg)
        else reportValue("regWrite", $sampled(regWrite), $sampled(mWb.writesReg));
    assert property (@(posedge clk) disable iff (!rst_n) !regWrite || regDest == mWb.dest)
        else reportValue("regDest", $sampled(regDest), $sampled(mWb.dest));
    assert property (@(posedge clk) disable iff (!rst_n) memToReg == mWb.isLoad)
        else reportValue("memToReg", $sampled(memToReg), $sampled(mWb.isLoad));
    assert property (@(posedge clk) disable iff (!rst_n) !mWb.valid |-> !regWrite)
        else reportEvent("register write issued for a bubble in WB");
    assert property (@(posedge clk) disable iff (!rst_n)
                     !(fwdA != FWD_NONE && mEx.rs == '0) && !(fwdB != FWD_NONE && mEx.rt == '0))
        else reportEvent("operand naming r0 was forwarded");

    // cycle limit, acceptance bookkeeping
    always @(posedge clk)
    begin
        cycleCnt   <= cycleCnt + 1;
        lastAccept <= instrValid && instrReady;
        if (rst_n && instrValid && instrReady)
            acceptCount <= acceptCount + 1;
        if (cycleCnt >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d, accepted: %0d, cycles: %0d", errCount, acceptCount, cycleCnt);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] randomWord();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] w;
        rs  = 5'($urandom_range(0, 3));      // r0..r3 keeps hazards frequent
        rt  = 5'($urandom_range(0, 3));
        rd  = 5'($urandom_range(0, 3));
        imm = 16'($urandom());
        case ($urandom_range(0, 16))
            0:       w = rWord(FN_ADD, rs, rt, rd);
            1:       w = rWord(FN_SUB, rs, rt, rd);
            2:       w = rWord(FN_AND, rs, rt, rd);
            3:       w = rWord(FN_OR, rs, rt, rd);
            4:       w = rWord(FN_SLT, rs, rt, rd);
            5:       w = iWord(OP_ADDI, rs, rt, imm);
            6:       w = iWord(OP_ANDI, rs, rt, imm);
            7:       w = iWord(OP_ORI, rs, rt, imm);
            8:       w = iWord(OP_SW, rs, rt, imm);
            9:       w = iWord(OP_BEQ, rs, rt, imm);
            10:      w = iWord(OP_BNE, rs, rt, imm);
            11:      w = iWord(OP_BGTZ, rs, 5'd0, imm);
            12:      w = {OP_J, 26'($urandom())};
            13:      w = rWord(FN_JR, rs, 5'd0, 5'd0);
            14:      w = iWord(6'h3f, rs, rt, imm);     // undefined opcode
            default: w = iWord(OP_LW, rs, rt, imm);
        endcase
        return w;
    endfunction

    // called at a falling edge, returns at the falling edge with the word in EX
    task automatic issue(input logic [31:0] word, input logic zero, input logic positive);
        instr      = word;
        instrValid = 1'b1;
        #1;
        while (!instrReady)
        begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        instrValid  = 1'b0;
        aluZero     = zero;          // flags describe the word now in EX
        aluPositive = positive;
    endtask

    task automatic idle(input int n);
        instrValid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    initial
    begin
        void'($urandom(32'h662e_fa03));
        rst_n       = 1'b0;
        instr       = '0;
        instrValid  = 1'b0;
        aluZero     = 1'b0;
        aluPositive = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // MEM forwarding, r0 never forwards
        issue(rWord(FN_ADD, 5'd2, 5'd3, 5'd1), 1'b0, 1'b0);
        issue(rWord(FN_SUB, 5'd1, 5'd0, 5'd4), 1'b0, 1'b0);
        issue(iWord(OP_ADDI, 5'd0, 5'd0, 16'h0005), 1'b0, 1'b0);
        issue(rWord(FN_OR, 5'd0, 5'd0, 5'd2), 1'b0, 1'b0);
        // WB forwarding, nearer MEM writer wins
        issue(rWord(FN_ADD, 5'd2, 5'd2, 5'd1), 1'b0, 1'b0);
        issue(rWord(FN_AND, 5'd3, 5'd3, 5'd2), 1'b0, 1'b0);
        issue(rWord(FN_SLT, 5'd1, 5'd2, 5'd3), 1'b0, 1'b0);
        issue(rWord(FN_ADD, 5'd1, 5'd1, 5'd3), 1'b0, 1'b0);
        issue(rWord(FN_OR, 5'd2, 5'd2, 5'd3), 1'b0, 1'b0);
        issue(rWord(FN_SUB, 5'd3, 5'd1, 5'd4), 1'b0, 1'b0);
        // load-use
        issue(iWord(OP_LW, 5'd1, 5'd2, 16'h0004), 1'b0, 1'b0);
        issue(rWord(FN_ADD, 5'd2, 5'd0, 5'd3), 1'b0, 1'b0);
        issue(iWord(OP_LW, 5'd1, 5'd3, 16'h0008), 1'b0, 1'b0);
        issue(iWord(OP_SW, 5'd1, 5'd3, 16'h0008), 1'b0, 1'b0);
        // branches, taken and not taken
        issue(iWord(OP_BEQ, 5'd1, 5'd2, 16'h0003), 1'b1, 1'b0);
        issue(iWord(OP_BEQ, 5'd1, 5'd2, 16'h0003), 1'b0, 1'b0);
        issue(iWord(OP_BNE, 5'd1, 5'd2, 16'h0003), 1'b0, 1'b0);
        issue(iWord(OP_BNE, 5'd1, 5'd2, 16'h0003), 1'b1, 1'b0);
        issue(iWord(OP_BGTZ, 5'd1, 5'd0, 16'h0003), 1'b0, 1'b1);
        issue(iWord(OP_BGTZ, 5'd1, 5'd0, 16'h0003), 1'b0, 1'b0);
        // jumps
        issue({OP_J, 26'h0000100}, 1'b0, 1'b0);
        issue(rWord(FN_JR, 5'd1, 5'd0, 5'd0), 1'b0, 1'b0);
        // branch on a loaded register waits before it resolves
        issue(iWord(OP_LW, 5'd1, 5'd2, 16'h0000), 1'b0, 1'b0);
        issue(iWord(OP_BEQ, 5'd2, 5'd1, 16'h0003), 1'b1, 1'b0);
        idle(4);

        for (i = 0; i < RAND_CYCLES; i++)
        begin
            @(negedge clk);
            if (!(instrValid && !lastAccept))    // hold an offer not yet taken
            begin
                instrValid = ($urandom_range(0, 3) != 0);
                instr      = randomWord();
            end
            aluZero     = ($urandom_range(0, 1) == 1);
            aluPositive = ($urandom_range(0, 1) == 1);
        end
        idle(6);

        $display("errors: %0d, accepted: %0d, cycles: %0d", errCount, acceptCount, cycleCnt);
        if (errCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
pipeCtrlPkg.sv
instrDecoder.sv
slotPipe.sv
hazardUnit.sv
redirectCtrl.sv
pipeCtrlTop.sv
tbPipeCtrl.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tbPipeCtrl
FILELIST   = all.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation completed successfully

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
